//--- Makefile
VERILATOR ?= verilator
TOP       ?= mpa_tb
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
source/mpa_config_pkg.sv
source/mpa_types_pkg.sv
source/mpa_links.sv
source/mpa_dispatch.sv
source/mpa_lane.sv
source/mpa_collect.sv
source/mpa_top.sv
verification/mpa_checker.sv
verification/mpa_tb.sv

//--- source/mpa_collect.sv
// Result collector draining per-lane buffers in round-robin issue order
module mpa_collect
    import mpa_types_pkg::*;
    import mpa_config_pkg::*;
(
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        out_ready,
    output logic        out_valid,
    output mpa_result_t out_data,
    mpa_result_if.dst   result [0:NUM_LANES-1]
);

    logic [LANE_IDX_W-1:0] drain_ptr;     // Follows the dispatcher rotation
    logic [NUM_LANES-1:0]  head_valid;
    mpa_result_t           head_data [NUM_LANES];
    logic                  take;

    assign out_valid = head_valid[drain_ptr];
    assign out_data  = head_data[drain_ptr];   // Held until taken
    assign take      = out_valid && out_ready;

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_buf
        mpa_result_t             mem [RESULT_DEPTH];
        logic [RESULT_PTR_W-1:0] wr_ptr;
        logic [RESULT_PTR_W-1:0] rd_ptr;
        logic [RESULT_CNT_W-1:0] cnt;
        logic                    pop;

        assign pop              = take && (drain_ptr == LANE_IDX_W'(i));
        assign result[i].credit = pop;
        assign head_valid[i]    = cnt != '0;
        assign head_data[i]     = mem[rd_ptr];

        always_ff @(posedge g_clk) begin
            if (result[i].valid)
                mem[wr_ptr] <= result[i].data;
        end

        // Lane credits keep pushes within RESULT_DEPTH
        always_ff @(posedge g_clk) begin
            if (!g_resetn) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                cnt    <= '0;
            end else begin
                if (result[i].valid)
                    wr_ptr <= (wr_ptr == RESULT_PTR_W'(RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                if (pop)
                    rd_ptr <= (rd_ptr == RESULT_PTR_W'(RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                case ({result[i].valid, pop})
                    2'b10:   cnt <= cnt + 1'b1;
                    2'b01:   cnt <= cnt - 1'b1;
                    default: cnt <= cnt;
                endcase
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            drain_ptr <= '0;
        end else if (take) begin
            drain_ptr <= (drain_ptr == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : drain_ptr + 1'b1;
        end
    end

endmodule

//--- source/mpa_config_pkg.sv
// Sizing constants for the multi-precision arithmetic unit
package mpa_config_pkg;

    // Lane count and round-robin pointer width
    localparam int NUM_LANES    = 4;
    localparam int LANE_IDX_W   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    localparam int ISSUE_DEPTH  = 2;   // Lane input queue entries
    localparam int ISSUE_PTR_W  = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
    localparam int ISSUE_CNT_W  = $clog2(ISSUE_DEPTH + 1);

    localparam int RESULT_DEPTH = 2;   // Collector buffer entries per lane
    localparam int RESULT_PTR_W = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
    localparam int RESULT_CNT_W = $clog2(RESULT_DEPTH + 1);

    localparam int WORD_W       = 32;
    localparam int DWORD_W      = 64;
    localparam int IMM_W        = 6;
    localparam int SHAMT_W      = 6;   // Funnel shift amount from 0 to 63

endpackage

//--- source/mpa_dispatch.sv
// Round-robin dispatcher issuing instructions to the lanes against per-lane credits
module mpa_dispatch
    import mpa_types_pkg::*;
    import mpa_config_pkg::*;
(
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              in_valid,
    input  mpa_op_e           in_op,
    input  logic [WORD_W-1:0] in_rs1,
    input  logic [WORD_W-1:0] in_rs2,
    input  logic [WORD_W-1:0] in_rs3,
    input  logic [IMM_W-1:0]  in_imm,
    output logic              in_ready,
    mpa_issue_if.src          issue [0:NUM_LANES-1]
);

    logic [LANE_IDX_W-1:0] rr_ptr;      // Lane receiving the next instruction
    logic [NUM_LANES-1:0]  has_credit;
    logic                  fire;
    mpa_issue_t            rec;

    assign rec      = '{op: in_op, rs1: in_rs1, rs2: in_rs2, rs3: in_rs3, imm: in_imm};
    assign in_ready = has_credit[rr_ptr];
    assign fire     = in_valid && in_ready;

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        logic [ISSUE_CNT_W-1:0] credit_cnt;

        assign issue[i].valid = fire && (rr_ptr == LANE_IDX_W'(i));
        assign issue[i].rec   = rec;
        assign has_credit[i]  = credit_cnt != '0;

        always_ff @(posedge g_clk) begin
            if (!g_resetn) begin
                credit_cnt <= ISSUE_CNT_W'(ISSUE_DEPTH);
            end else begin
                case ({issue[i].valid, issue[i].credit})
                    2'b10:   credit_cnt <= credit_cnt - 1'b1;
                    2'b01:   credit_cnt <= credit_cnt + 1'b1;
                    default: credit_cnt <= credit_cnt;   // Both or neither
                endcase
            end
        end
    end

    // Strict rotation lets the collector restore issue order
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rr_ptr <= '0;
        end else if (fire) begin
            rr_ptr <= (rr_ptr == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : rr_ptr + 1'b1;
        end
    end

endmodule

//--- source/mpa_lane.sv
// Arithmetic lane with input queue and multi-step multi-precision datapath
module mpa_lane
    import mpa_types_pkg::*;
    import mpa_config_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,
    mpa_issue_if.dst  issue,
    mpa_result_if.src result
);

    mpa_issue_t              q_mem [ISSUE_DEPTH];
    logic [ISSUE_PTR_W-1:0]  q_wr;
    logic [ISSUE_PTR_W-1:0]  q_rd;
    logic [ISSUE_CNT_W-1:0]  q_cnt;
    logic                    q_pop;

    mpa_step_e               step;
    mpa_issue_t              cur;           // Entry in flight after STEP0
    mpa_issue_t              op_rec;
    logic [DWORD_W-1:0]      tmp;
    logic [DWORD_W-1:0]      n_tmp;
    logic [RESULT_CNT_W-1:0] res_credit;

    logic                    is_cmp;
    logic                    is_two;
    logic                    is_shf;
    logic                    is_acc;
    logic                    do_sub;
    logic                    active;
    logic                    last;
    logic                    advance;
    logic                    finish;

    logic [DWORD_W-1:0]      add_lhs;
    logic [DWORD_W-1:0]      add_rhs;
    logic [DWORD_W-1:0]      add_res;
    logic [DWORD_W-1:0]      mul_res;
    logic [DWORD_W-1:0]      shf_res;
    logic [SHAMT_W-1:0]      shamt;
    logic                    cmp_eq;
    logic                    cmp_lt;
    logic                    cmp_nz;
    logic                    cmp_res;

    always_ff @(posedge g_clk) begin
        if (issue.valid)
            q_mem[q_wr] <= issue.rec;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            q_wr  <= '0;
            q_rd  <= '0;
            q_cnt <= '0;
        end else begin
            if (issue.valid)
                q_wr <= (q_wr == ISSUE_PTR_W'(ISSUE_DEPTH - 1)) ? '0 : q_wr + 1'b1;
            if (q_pop)
                q_rd <= (q_rd == ISSUE_PTR_W'(ISSUE_DEPTH - 1)) ? '0 : q_rd + 1'b1;
            case ({issue.valid, q_pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    // STEP0 works straight from the queue head
    assign op_rec = (step == STEP0) ? q_mem[q_rd] : cur;

    assign is_cmp = op_rec.op inside {EQU, LTU, GTU};
    assign is_two = op_rec.op inside {ADD2, SUB2, ACC1, SLL, SLLI, SRL, SRLI};
    assign is_shf = op_rec.op inside {SLL, SLLI, SRL, SRLI};
    assign is_acc = op_rec.op inside {ACC1, ACC2};
    assign do_sub = op_rec.op inside {SUB2, SUB3};

    assign active  = (step != STEP0) || (q_cnt != '0);
    assign last    = (step == STEP0 && is_cmp) || (step == STEP1 && is_two) || (step == STEP2);
    assign advance = active && (!last || res_credit != '0);   // Stall in last step
    assign finish  = advance && last;
    assign q_pop   = advance && (step == STEP0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            step <= STEP0;
        end else if (advance) begin
            case (step)
                STEP0:   step <= last ? STEP0 : STEP1;
                STEP1:   step <= last ? STEP0 : STEP2;
                default: step <= STEP0;
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            res_credit <= RESULT_CNT_W'(RESULT_DEPTH);
        end else begin
            case ({finish, result.credit})
                2'b10:   res_credit <= res_credit - 1'b1;
                2'b01:   res_credit <= res_credit + 1'b1;
                default: res_credit <= res_credit;
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (q_pop)
            cur <= q_mem[q_rd];
        if (advance && !last)
            tmp <= n_tmp;
    end

    // Adder takes rs1 first, then accumulates onto tmp
    assign add_lhs = (step == STEP0) ? DWORD_W'(op_rec.rs1) : tmp;
    assign add_rhs = (step == STEP0) ?
                         (is_acc ? {op_rec.rs2, op_rec.rs3} : DWORD_W'(op_rec.rs2)) :
                         ((op_rec.op == ACC2) ? DWORD_W'(op_rec.rs2) : DWORD_W'(op_rec.rs3));
    assign add_res = do_sub ? add_lhs - add_rhs : add_lhs + add_rhs;

    assign mul_res = DWORD_W'(op_rec.rs1) * DWORD_W'(op_rec.rs2);

    // Funnel shift of rs1:rs2
    assign shamt   = (op_rec.op inside {SLLI, SRLI}) ? op_rec.imm[SHAMT_W-1:0] :
                                                       op_rec.rs3[SHAMT_W-1:0];
    assign shf_res = (op_rec.op inside {SRL, SRLI}) ? {op_rec.rs1, op_rec.rs2} >> shamt :
                                                      {op_rec.rs1, op_rec.rs2} << shamt;

    assign cmp_eq  = op_rec.rs2 == op_rec.rs3;
    assign cmp_lt  = op_rec.rs2 <  op_rec.rs3;
    assign cmp_nz  = |op_rec.rs1;            // Carried flag
    assign cmp_res = (op_rec.op == EQU) ? (cmp_eq && cmp_nz) :
                     (op_rec.op == LTU) ? (cmp_lt || (cmp_eq && cmp_nz)) :
                                          ((!cmp_lt && !cmp_eq) || (cmp_eq && cmp_nz));

    assign n_tmp = (step == STEP0 && op_rec.op == MAC) ? mul_res :
                   (step == STEP0 && is_shf)           ? shf_res :
                                                         add_res;

    assign issue.credit = q_pop;
    assign result.valid = finish;
    assign result.data  = is_cmp ? DWORD_W'(cmp_res) : tmp;

endmodule

//--- source/mpa_links.sv
// Credit-based issue and result links between dispatcher, lanes and collector

// Dispatcher to lane link with one instance per lane
interface mpa_issue_if
    import mpa_types_pkg::*;
();

    logic       valid;      // Record written into the lane queue
    mpa_issue_t rec;
    logic       credit;     // Lane popped one queue entry

    modport src (
        output valid,
        output rec,
        input  credit
    );

    modport dst (
        input  valid,
        input  rec,
        output credit
    );

endinterface

// Lane to collector link with one instance per lane
interface mpa_result_if
    import mpa_types_pkg::*;
();

    logic        valid;     // Finished result, pushed into the lane buffer
    mpa_result_t data;
    logic        credit;    // Collector drained one buffer entry

    modport src (
        output valid,
        output data,
        input  credit
    );

    modport dst (
        input  valid,
        input  data,
        output credit
    );

endinterface

//--- source/mpa_top.sv
// Multi-precision arithmetic unit with dispatcher, parallel lanes and in-order collector
module mpa_top
    import mpa_types_pkg::*;
    import mpa_config_pkg::*;
(
    input  logic               g_clk,
    input  logic               g_resetn,
    input  logic               in_valid,
    input  mpa_op_e            in_op,
    input  logic [WORD_W-1:0]  in_rs1,
    input  logic [WORD_W-1:0]  in_rs2,
    input  logic [WORD_W-1:0]  in_rs3,
    input  logic [IMM_W-1:0]   in_imm,
    output logic               in_ready,
    output logic               out_valid,
    output logic [DWORD_W-1:0] out_data,
    input  logic               out_ready
);

    mpa_issue_if  issue_link  [0:NUM_LANES-1] ();
    mpa_result_if result_link [0:NUM_LANES-1] ();

    mpa_dispatch i_mpa_dispatch (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_rs3   (in_rs3),
        .in_imm   (in_imm),
        .in_ready (in_ready),
        .issue    (issue_link)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        mpa_lane i_mpa_lane (
            .g_clk    (g_clk),
            .g_resetn (g_resetn),
            .issue    (issue_link[i]),
            .result   (result_link[i])
        );
    end

    mpa_collect i_mpa_collect (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .result    (result_link)
    );

endmodule

//--- source/mpa_types_pkg.sv
// Opcode, lane step and record types of the multi-precision arithmetic unit
package mpa_types_pkg;

    import mpa_config_pkg::*;

    typedef enum logic [3:0] {
        EQU,    // Compare ops take one step
        LTU,
        GTU,
        ADD2,
        ADD3,
        SUB2,
        SUB3,
        SLL,
        SLLI,
        SRL,
        SRLI,
        ACC1,
        ACC2,
        MAC     // Multiply then add in three steps
    } mpa_op_e;

    // STEP0 doubles as the idle state of a lane
    typedef enum logic [1:0] {
        STEP0,
        STEP1,
        STEP2
    } mpa_step_e;

    typedef struct packed {
        mpa_op_e            op;
        logic [WORD_W-1:0]  rs1;
        logic [WORD_W-1:0]  rs2;
        logic [WORD_W-1:0]  rs3;
        logic [IMM_W-1:0]   imm;
    } mpa_issue_t;

    typedef logic [DWORD_W-1:0] mpa_result_t;

endpackage

//--- verification/mpa_checker.sv
// Output checker matching every result transfer against the queue of expected values
module mpa_checker
    import mpa_config_pkg::*;
(
    input  logic               g_clk,
    input  logic               g_resetn,
    input  logic               in_ready,
    input  logic               out_valid,
    input  logic               out_ready,
    input  logic [DWORD_W-1:0] out_data
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [DWORD_W-1:0] exp_q  [$];   // Filled by the driver in issue order
    logic [127:0]       name_q [$];
    int                 checked;
    int                 errors;
    int                 idle_errs;

    initial begin
        checked   = 0;
        errors    = 0;
        idle_errs = 0;
    end

    task automatic expect_result(input logic [127:0] name, input logic [DWORD_W-1:0] value);
        name_q.push_back(name);
        exp_q.push_back(value);
    endtask

    // No result pending and room for input
    task automatic check_idle();
        if (out_valid !== 1'b0) begin
            $display("mismatch out_valid around reset: got 0x%h, expected 0x0", out_valid);
            idle_errs++;
        end
        if (in_ready !== 1'b1) begin
            $display("mismatch in_ready around reset: got 0x%h, expected 0x1", in_ready);
            idle_errs++;
        end
    endtask

    task automatic report_reset();
        if (idle_errs == 0)
            $display("reset_state ok");
        errors += idle_errs;
    endtask

    // Transfer happens on the edge where both valid and ready are high
    always @(posedge g_clk) begin
        logic [DWORD_W-1:0] exp_val;
        logic [127:0]       name;
        if (g_resetn && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected result 0x%h with no instruction pending", out_data);
                errors++;
            end else begin
                exp_val = exp_q.pop_front();
                name    = name_q.pop_front();
                checked++;
                if (out_data !== exp_val) begin
                    $display("mismatch out_data in %0s: got 0x%h, expected 0x%h",
                             name, out_data, exp_val);
                    errors++;
                end else begin
                    $display("%0s ok, out_data 0x%h", name, out_data);
                end
            end
        end
    end

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(negedge g_clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d results never came out of the DUT", exp_q.size());
            errors += exp_q.size();
            exp_q.delete();
            name_q.delete();
        end
    endtask

endmodule

//--- verification/mpa_stim.txt
# name op rs1 rs2 rs3 imm expected, all values in hex
# op: 0 EQU 1 LTU 2 GTU 3 ADD2 4 ADD3 5 SUB2 6 SUB3 7 SLL 8 SLLI 9 SRL a SRLI b ACC1 c ACC2 d MAC
add2_plain   3 12345678 87654321 00000000 00 0000000099999999
add2_carry   3 ffffffff 00000001 00000000 00 0000000100000000
add3_carry   4 ffffffff ffffffff ffffffff 00 00000002fffffffd
sub2_borrow  5 00000001 00000002 00000000 00 ffffffffffffffff
sub3_plain   6 80000000 10000000 00000001 00 000000006fffffff
sub3_borrow  6 00000005 00000003 00000004 00 fffffffffffffffe
acc1_carry   b 80000000 00000001 80000000 00 0000000200000000
acc1_wrap    b 00000001 ffffffff ffffffff 00 0000000000000000
acc2_wrap    c 00000010 ffffffff 00000000 00 000000000000000f
mac_small    d 00012345 00000100 00000007 00 0000000001234507
mac_max      d ffffffff ffffffff ffffffff 00 ffffffff00000000
sll_0        7 80000001 00000003 00000000 00 8000000100000003
slli_1       8 80000001 00000003 00000000 01 0000000200000006
sll_31       7 80000001 00000003 0000001f 05 8000000180000000
slli_32      8 80000001 00000003 00000000 20 0000000300000000
sll_63       7 80000001 00000003 ffffffff 00 8000000000000000
srl_0        9 80000001 00000003 00000040 00 8000000100000003
srli_1       a 80000001 00000003 00000000 01 4000000080000001
srl_31       9 80000001 00000003 0000001f 00 0000000100000002
srli_32      a 80000001 00000003 00000000 20 0000000080000001
srli_63      a 80000001 00000003 00000000 3f 0000000000000001
equ_eq_nz    0 00000001 00000005 00000005 00 0000000000000001
equ_eq_z     0 00000000 00000005 00000005 00 0000000000000000
equ_ne_nz    0 00000001 00000004 00000005 00 0000000000000000
ltu_lt_z     1 00000000 00000004 00000005 00 0000000000000001
ltu_eq_z     1 00000000 00000005 00000005 00 0000000000000000
ltu_eq_nz    1 00000001 00000005 00000005 00 0000000000000001
ltu_gt_nz    1 00000001 00000006 00000005 00 0000000000000000
gtu_gt_z     2 00000000 ffffffff 00000000 00 0000000000000001
gtu_eq_z     2 00000000 00000007 00000007 00 0000000000000000
gtu_eq_nz    2 80000000 00000007 00000007 00 0000000000000001
gtu_lt_nz    2 00000001 00000006 00000007 00 0000000000000000

//--- verification/mpa_tb.sv
// Testbench for the multi-precision arithmetic unit driven from a stimulus file
module mpa_tb
    import mpa_types_pkg::*;
    import mpa_config_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_VECS = 64;
    localparam int WAIT_MAX = 2000;     // Cycles allowed for any single wait

    logic               g_clk;
    logic               g_resetn;
    logic               in_valid;
    mpa_op_e            in_op;
    logic [WORD_W-1:0]  in_rs1;
    logic [WORD_W-1:0]  in_rs2;
    logic [WORD_W-1:0]  in_rs3;
    logic [IMM_W-1:0]   in_imm;
    logic               in_ready;
    logic               out_valid;
    logic [DWORD_W-1:0] out_data;
    logic               out_ready;

    logic [127:0]       name_mem [MAX_VECS];
    logic [3:0]         op_mem   [MAX_VECS];
    logic [WORD_W-1:0]  rs1_mem  [MAX_VECS];
    logic [WORD_W-1:0]  rs2_mem  [MAX_VECS];
    logic [WORD_W-1:0]  rs3_mem  [MAX_VECS];
    logic [IMM_W-1:0]   imm_mem  [MAX_VECS];
    logic [DWORD_W-1:0] exp_mem  [MAX_VECS];
    int                 num_vecs;
    int                 tb_errs;
    int                 stall_mode;     // 0 never stalled, 1 random stalls, 2 held low
    logic               timed_out;
    logic [31:0]        rng;

    mpa_top i_mpa_top (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .in_rs3    (in_rs3),
        .in_imm    (in_imm),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    mpa_checker i_mpa_checker (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Sink side drops out_ready on about one cycle in four
    initial begin
        out_ready = 1'b1;
        rng       = 32'hd7e1cd50;
        forever begin
            @(negedge g_clk);
            rng = xorshift(rng);
            if (stall_mode == 0)
                out_ready = 1'b1;
            else if (stall_mode == 1)
                out_ready = (rng[1:0] != 2'b00);
            else
                out_ready = 1'b0;
        end
    end

    task automatic load_vectors();
        int           fd;
        int           cnt;
        string        line;
        logic [127:0] name;
        logic [31:0]  op;
        logic [31:0]  r1;
        logic [31:0]  r2;
        logic [31:0]  r3;
        logic [31:0]  imm;
        logic [63:0]  exp_val;
        num_vecs = 0;
        fd = $fopen("verification/mpa_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file verification/mpa_stim.txt");
            tb_errs++;
        end else begin
            while (!$feof(fd) && num_vecs < MAX_VECS) begin
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.len() > 1 && line[0] != "#") begin
                    cnt = $sscanf(line, "%s %h %h %h %h %h %h",
                                  name, op, r1, r2, r3, imm, exp_val);
                    if (cnt == 7) begin
                        name_mem[num_vecs] = name;
                        op_mem[num_vecs]   = op[3:0];
                        rs1_mem[num_vecs]  = r1;
                        rs2_mem[num_vecs]  = r2;
                        rs3_mem[num_vecs]  = r3;
                        imm_mem[num_vecs]  = imm[IMM_W-1:0];
                        exp_mem[num_vecs]  = exp_val;
                        num_vecs++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Enters at a falling edge and leaves one falling edge after acceptance
    task automatic send_vector(input int idx);
        int n;
        n        = 0;
        in_valid = 1'b1;
        in_op    = mpa_op_e'(op_mem[idx]);
        in_rs1   = rs1_mem[idx];
        in_rs2   = rs2_mem[idx];
        in_rs3   = rs3_mem[idx];
        in_imm   = imm_mem[idx];
        while (!in_ready && n < WAIT_MAX) begin
            @(negedge g_clk);
            n++;
        end
        if (!in_ready) begin
            in_valid = 1'b0;
            $display("Timeout: in_ready stayed low for %0d cycles at %0s", n, name_mem[idx]);
            tb_errs++;
            timed_out = 1'b1;
        end else begin
            i_mpa_checker.expect_result(name_mem[idx], exp_mem[idx]);
            @(negedge g_clk);
            in_valid = 1'b0;
        end
    endtask

    // Interleaving puts one-step compares right behind three-step ops
    task automatic run_vectors(input bit interleave);
        int idx;
        for (int i = 0; i < num_vecs; i++) begin
            idx = interleave ? ((i % 2 == 0) ? i / 2 : num_vecs - 1 - i / 2) : i;
            if (!timed_out)
                send_vector(idx);
        end
    endtask

    task automatic hold_until_full();
        int n;
        n = 0;
        while (in_ready && n < WAIT_MAX) begin
            @(negedge g_clk);
            n++;
        end
        if (in_ready) begin
            $display("in_ready never fell while out_ready was held low");
            tb_errs++;
        end else begin
            $display("backpressure ok, in_ready fell after %0d cycles", n);
        end
        repeat (20) @(negedge g_clk);
        stall_mode = 1;   // Release into random stalls
    endtask

    initial begin
        int errs;
        g_resetn   = 1'b0;
        in_valid   = 1'b0;
        in_op      = EQU;
        in_rs1     = '0;
        in_rs2     = '0;
        in_rs3     = '0;
        in_imm     = '0;
        stall_mode = 0;
        tb_errs    = 0;
        timed_out  = 1'b0;
        load_vectors();
        if (num_vecs == 0) begin
            $display("No instructions were read from the stimulus file");
            tb_errs++;
        end

        repeat (8) begin
            @(negedge g_clk);
            i_mpa_checker.check_idle();
        end
        g_resetn = 1'b1;
        repeat (2) begin
            @(negedge g_clk);
            i_mpa_checker.check_idle();
        end
        i_mpa_checker.report_reset();

        run_vectors(1'b1);        // Back-to-back burst
        i_mpa_checker.wait_drained(WAIT_MAX);

        stall_mode = 1;
        run_vectors(1'b0);
        i_mpa_checker.wait_drained(WAIT_MAX);

        stall_mode = 2;           // Long stall until the input side backs up
        fork
            run_vectors(1'b0);
            hold_until_full();
        join
        i_mpa_checker.wait_drained(WAIT_MAX);

        errs = i_mpa_checker.errors + tb_errs;
        $display("Checked %0d of %0d results, %0d errors",
                 i_mpa_checker.checked, 3 * num_vecs, errs);
        if (errs == 0 && num_vecs > 0 && i_mpa_checker.checked == 3 * num_vecs)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
